// ==== opstage_pkg.sv ====
// Shared types and constants for the operand stage
// Instruction words are always 32 bits whatever the data width
// The immediate is 16 bits so the data width must be at least 16
// Opcodes outside the list below decode as no-ops that never write

package opstage_pkg;

	// Default operand width
	localparam int DATA_WIDTH = 32;

	// 32 architectural registers
	localparam int REG_ADDR_W = 5;

	//////////////////////////////////////////////////////////////////////
	// Instruction word
	//////////////////////////////////////////////////////////////////////

	// Same 32 bits read as register-register or register-immediate
	typedef union packed {
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rd;
			logic [4:0]  ra;
			logic [4:0]  rb;
			logic [10:0] func;  // reserved
		} r_fmt;
		struct packed {
			logic [5:0]  opcode;
			logic [4:0]  rd;
			logic [4:0]  ra;
			logic [15:0] imm;
		} i_fmt;
	} insn_t;

	// Register-register opcodes
	localparam logic [5:0] OP_ADD  = 6'h20;
	localparam logic [5:0] OP_SUB  = 6'h21;
	localparam logic [5:0] OP_AND  = 6'h22;
	localparam logic [5:0] OP_OR   = 6'h23;
	localparam logic [5:0] OP_XOR  = 6'h24;

	// Register-immediate opcode
	localparam logic [5:0] OP_ADDI = 6'h27;

	//////////////////////////////////////////////////////////////////////
	// Stage control codes
	//////////////////////////////////////////////////////////////////////

	// ALU function carried from decode into EX
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4
	} alu_op_t;

	// Operand source select
	typedef enum logic [1:0] {
		SEL_RF      = 2'd0,
		SEL_IMM     = 2'd1,
		SEL_EX_FORW = 2'd2,
		SEL_WB_FORW = 2'd3
	} sel_t;

endpackage

// ==== reg_file.sv ====
// Register file with 32 entries
// Two combinational read ports and one write port on the rising edge
// Register 0 always reads zero and ignores writes
// A write is seen on the read ports only after its edge
// Reset clears every entry

`timescale 1ns/1ps

module reg_file import opstage_pkg::*; #(
	parameter int width = DATA_WIDTH
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [REG_ADDR_W-1:0] ra_addr,
	input  logic [REG_ADDR_W-1:0] rb_addr,
	input  logic                  we,
	input  logic [REG_ADDR_W-1:0] wd_addr,
	input  logic [width-1:0]      wd_data,
	output logic [width-1:0]      rf_dataa,
	output logic [width-1:0]      rf_datab
);

	// Storage
	logic [width-1:0] regs [2**REG_ADDR_W];

	// Write port
	always_ff @(posedge clk) begin
		if (reset) begin
			// Known start values for the whole array
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wd_addr != '0)) begin
			regs[wd_addr] <= wd_data;
		end
	end

	// Read port A
	// Register 0 forced to zero
	assign rf_dataa = (ra_addr == '0) ? '0 : regs[ra_addr];

	// Read port B
	assign rf_datab = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule

// ==== forward_select.sv ====
// Decode and forwarding select, purely combinational
// EX and WB destinations arrive with their valid bits already qualified
// Register 0 is never forwarded
// Unknown opcodes give id_valid low

`timescale 1ns/1ps

module forward_select import opstage_pkg::*; #(
	parameter int width = DATA_WIDTH
) (
	input  insn_t                 insn,
	input  logic                  insn_valid,
	input  logic [REG_ADDR_W-1:0] ex_rd,
	input  logic                  ex_valid,
	input  logic [REG_ADDR_W-1:0] wb_rd,
	input  logic                  wb_valid,
	output logic [REG_ADDR_W-1:0] ra_addr,
	output logic [REG_ADDR_W-1:0] rb_addr,
	output sel_t                  sel_a,
	output sel_t                  sel_b,
	output logic [width-1:0]      simm,
	output logic [REG_ADDR_W-1:0] id_rd,
	output alu_op_t               id_op,
	output logic                  id_valid
);

	logic is_imm;
	logic known_op;

	// Forwarding priority for one source
	// Nearest producer wins
	function automatic sel_t src_sel(
		input logic [REG_ADDR_W-1:0] src,
		input logic [REG_ADDR_W-1:0] e_rd,
		input logic                  e_vld,
		input logic [REG_ADDR_W-1:0] w_rd,
		input logic                  w_vld
	);
		sel_t sel;
		if (src == '0) begin
			sel = SEL_RF;
		end else if (e_vld && (e_rd == src)) begin
			sel = SEL_EX_FORW;
		end else if (w_vld && (w_rd == src)) begin
			sel = SEL_WB_FORW;
		end else begin
			sel = SEL_RF;
		end
		return sel;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Opcode decode
	//////////////////////////////////////////////////////////////////////

	// Opcode sits in the same bits in both layouts
	always_comb begin
		is_imm   = 1'b0;
		known_op = 1'b1;
		id_op    = ALU_ADD;
		case (insn.r_fmt.opcode)
			OP_ADD:  id_op = ALU_ADD;
			OP_SUB:  id_op = ALU_SUB;
			OP_AND:  id_op = ALU_AND;
			OP_OR:   id_op = ALU_OR;
			OP_XOR:  id_op = ALU_XOR;
			OP_ADDI: begin
				id_op  = ALU_ADD;
				is_imm = 1'b1;
			end
			default: known_op = 1'b0;
		endcase
	end

	// rd and ra share their bits in both layouts
	assign ra_addr  = insn.r_fmt.ra;
	assign id_rd    = insn.r_fmt.rd;
	assign rb_addr  = insn.r_fmt.rb;   // don't care for addi
	assign simm     = {{(width-16){insn.i_fmt.imm[15]}}, insn.i_fmt.imm};
	assign id_valid = insn_valid && known_op;

	// Operand selects
	// Immediate overrides any hazard on B
	assign sel_a = src_sel(ra_addr, ex_rd, ex_valid, wb_rd, wb_valid);
	assign sel_b = is_imm ? SEL_IMM : src_sel(rb_addr, ex_rd, ex_valid, wb_rd, wb_valid);

endmodule

// ==== operand_muxes.sv ====
// Forwarding muxes and EX operand registers
// ex_freeze high holds both operand registers
// First id_freeze cycle saves the muxed operands for the held instruction
// Saved operands go to EX on the edge that ends the freeze
// Operand A has no immediate path

`timescale 1ns/1ps

module operand_muxes import opstage_pkg::*; #(
	parameter int width = DATA_WIDTH
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             id_freeze,
	input  logic             ex_freeze,
	input  logic [width-1:0] rf_dataa,
	input  logic [width-1:0] rf_datab,
	input  logic [width-1:0] ex_forw,
	input  logic [width-1:0] wb_forw,
	input  logic [width-1:0] simm,
	input  sel_t             sel_a,
	input  sel_t             sel_b,
	output logic [width-1:0] operand_a,
	output logic [width-1:0] operand_b,
	output logic [width-1:0] muxed_a,
	output logic [width-1:0] muxed_b
);

	// Lane 0 is operand A and lane 1 is operand B
	logic [width-1:0] mux_lane [2];
	logic [width-1:0] op_lane  [2];
	logic             saved    [2];

	//////////////////////////////////////////////////////////////////////
	// Forwarding muxes
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Operand A
		case (sel_a)
			SEL_EX_FORW: mux_lane[0] = ex_forw;
			SEL_WB_FORW: mux_lane[0] = wb_forw;
			default:     mux_lane[0] = rf_dataa;
		endcase
		// Operand B
		case (sel_b)
			SEL_IMM:     mux_lane[1] = simm;
			SEL_EX_FORW: mux_lane[1] = ex_forw;
			SEL_WB_FORW: mux_lane[1] = wb_forw;
			default:     mux_lane[1] = rf_datab;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Operand registers
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 2; i++) begin : g_lane
		always_ff @(posedge clk) begin
			if (reset) begin
				op_lane[i] <= '0;
				saved[i]   <= 1'b0;
			end else if (!ex_freeze && id_freeze && !saved[i]) begin
				// First ID-only freeze cycle
				op_lane[i] <= mux_lane[i];
				saved[i]   <= 1'b1;
			end else if (!ex_freeze && !saved[i]) begin
				op_lane[i] <= mux_lane[i];
			end else if (!ex_freeze && !id_freeze) begin
				// Freeze over, keep the saved value one more cycle
				saved[i] <= 1'b0;
			end
		end
	end

	assign muxed_a   = mux_lane[0];
	assign muxed_b   = mux_lane[1];
	assign operand_a = op_lane[0];
	assign operand_b = op_lane[1];

endmodule

// ==== exec_unit.sv ====
// Single-cycle execute stage and writeback register
// ex_freeze holds EX and WB and blocks the commit
// id_freeze alone sends a bubble into EX
// wb_commit is also the register file write enable
// ALU wraps on overflow

`timescale 1ns/1ps

module exec_unit import opstage_pkg::*; #(
	parameter int width = DATA_WIDTH
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	input  logic                  id_valid,
	input  alu_op_t               id_op,
	input  logic [REG_ADDR_W-1:0] id_rd,
	input  logic [width-1:0]      operand_a,
	input  logic [width-1:0]      operand_b,
	output logic [width-1:0]      ex_forw,
	output logic [REG_ADDR_W-1:0] ex_rd,
	output logic                  ex_valid,
	output logic [width-1:0]      wb_forw,
	output logic [REG_ADDR_W-1:0] wb_rd,
	output logic                  wb_valid,
	output logic                  wb_commit
);

	alu_op_t ex_op;

	//////////////////////////////////////////////////////////////////////
	// EX control register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid <= 1'b0;
			ex_op    <= ALU_ADD;
		end else if (!ex_freeze) begin
			if (id_freeze) begin
				// Bubble while decode waits
				ex_valid <= 1'b0;
			end else begin
				ex_valid <= id_valid;
				ex_op    <= id_op;
			end
		end
	end

	// Destination only matters while ex_valid is set
	always_ff @(posedge clk) begin
		if (!ex_freeze && !id_freeze) begin
			ex_rd <= id_rd;
		end
	end

	// ALU
	always_comb begin
		case (ex_op)
			ALU_ADD: ex_forw = operand_a + operand_b;
			ALU_SUB: ex_forw = operand_a - operand_b;
			ALU_AND: ex_forw = operand_a & operand_b;
			ALU_OR:  ex_forw = operand_a | operand_b;
			ALU_XOR: ex_forw = operand_a ^ operand_b;
			default: ex_forw = operand_a + operand_b;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// WB register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else if (!ex_freeze) begin
			wb_valid <= ex_valid;
		end
	end

	// Result and destination
	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_forw <= ex_forw;
			wb_rd   <= ex_rd;
		end
	end

	// One pulse per instruction since WB advances on the same condition
	assign wb_commit = wb_valid && !ex_freeze;

endmodule

// ==== operand_stage.sv ====
// Operand stage top level
// The environment holds insn steady while either freeze is high
// Results appear on wb_data in the cycle wb_commit is high
// Up to two instructions are in flight past decode

`timescale 1ns/1ps

module operand_stage import opstage_pkg::*; #(
	parameter int width = DATA_WIDTH
) (
	input  logic                  clk,
	input  logic                  reset,
	input  insn_t                 insn,
	input  logic                  insn_valid,
	input  logic                  id_freeze,
	input  logic                  ex_freeze,
	output logic [width-1:0]      operand_a,
	output logic [width-1:0]      operand_b,
	output logic                  wb_commit,
	output logic [REG_ADDR_W-1:0] wb_rd,
	output logic [width-1:0]      wb_data
);

	// Decode to register file and operand muxes
	logic [REG_ADDR_W-1:0] ra_addr;
	logic [REG_ADDR_W-1:0] rb_addr;
	sel_t                  sel_a;
	sel_t                  sel_b;
	logic [width-1:0]      simm;
	logic [REG_ADDR_W-1:0] id_rd;
	alu_op_t               id_op;
	logic                  id_valid;

	// Register file read data
	logic [width-1:0]      rf_dataa;
	logic [width-1:0]      rf_datab;

	// Forwarding and hazard feedback
	logic [width-1:0]      ex_forw;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic                  ex_valid;
	logic                  wb_valid;

	reg_file #(.width(width)) reg_file_inst (
		.clk      (clk),
		.reset    (reset),
		.ra_addr  (ra_addr),
		.rb_addr  (rb_addr),
		.we       (wb_commit),
		.wd_addr  (wb_rd),
		.wd_data  (wb_data),
		.rf_dataa (rf_dataa),
		.rf_datab (rf_datab)
	);

	forward_select #(.width(width)) forward_select_inst (
		.insn       (insn),
		.insn_valid (insn_valid),
		.ex_rd      (ex_rd),
		.ex_valid   (ex_valid),
		.wb_rd      (wb_rd),
		.wb_valid   (wb_valid),
		.ra_addr    (ra_addr),
		.rb_addr    (rb_addr),
		.sel_a      (sel_a),
		.sel_b      (sel_b),
		.simm       (simm),
		.id_rd      (id_rd),
		.id_op      (id_op),
		.id_valid   (id_valid)
	);

	// Muxed values are observed only inside the block
	operand_muxes #(.width(width)) operand_muxes_inst (
		.clk       (clk),
		.reset     (reset),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_dataa  (rf_dataa),
		.rf_datab  (rf_datab),
		.ex_forw   (ex_forw),
		.wb_forw   (wb_data),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.muxed_a   (),
		.muxed_b   ()
	);

	// WB result doubles as the forwarding source and the write data
	exec_unit #(.width(width)) exec_unit_inst (
		.clk       (clk),
		.reset     (reset),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.id_valid  (id_valid),
		.id_op     (id_op),
		.id_rd     (id_rd),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ex_forw   (ex_forw),
		.ex_rd     (ex_rd),
		.ex_valid  (ex_valid),
		.wb_forw   (wb_data),
		.wb_rd     (wb_rd),
		.wb_valid  (wb_valid),
		.wb_commit (wb_commit)
	);

endmodule

// ==== operand_muxes_asserts.sv ====
// Concurrent checks on the operand registers
// Bound into every operand_muxes instance
// Saved flags are the internal per-lane flags of the block

`timescale 1ns/1ps

module operand_muxes_asserts import opstage_pkg::*; #(
	parameter int width = DATA_WIDTH
) (
	input logic             clk,
	input logic             reset,
	input logic             id_freeze,
	input logic             ex_freeze,
	input logic [width-1:0] operand_a,
	input logic [width-1:0] operand_b,
	input logic             saved_a,
	input logic             saved_b
);

	//////////////////////////////////////////////////////////////////////
	// Hold behaviour
	//////////////////////////////////////////////////////////////////////

	// EX frozen means both operands keep their value
	a_ex_freeze_hold: assert property (@(posedge clk) disable iff (reset)
		ex_freeze |=> $stable(operand_a) && $stable(operand_b))
		else $error("operands changed under ex_freeze");

	// Saved operand A waits for the held instruction
	a_saved_hold: assert property (@(posedge clk) disable iff (reset)
		saved_a |=> $stable(operand_a))
		else $error("operand_a changed while saved");

	// Flag only rises after an ID-only freeze
	a_saved_rise: assert property (@(posedge clk) disable iff (reset)
		$rose(saved_a) |-> $past(id_freeze && !ex_freeze))
		else $error("saved flag set without an ID freeze");

	// Clean state right after reset
	a_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !saved_a && !saved_b && operand_a == '0 && operand_b == '0)
		else $error("operand state not cleared by reset");

endmodule

bind operand_muxes operand_muxes_asserts #(.width(width)) operand_muxes_asserts_inst (
	.clk       (clk),
	.reset     (reset),
	.id_freeze (id_freeze),
	.ex_freeze (ex_freeze),
	.operand_a (operand_a),
	.operand_b (operand_b),
	.saved_a   (saved[0]),
	.saved_b   (saved[1])
);

// ==== tb_operand_stage.sv ====
// Testbench for the operand stage
// Random instructions on registers 0 to 3 so hazards are frequent
// Inputs change on the falling edge and outputs are checked there too
// The instruction is held while either freeze is high

`timescale 1ns/1ps

module tb_operand_stage import opstage_pkg::*; #(
	parameter int seed_init = 32'h6f20
);

	localparam int width        = DATA_WIDTH;
	localparam int n_insn       = 400;
	localparam int max_cpi      = 8;
	localparam int clk_period   = 8;
	localparam int reset_cycles = 5;

	logic                  clk;
	logic                  reset;
	insn_t                 insn;
	logic                  insn_valid;
	logic                  id_freeze;
	logic                  ex_freeze;
	logic [width-1:0]      operand_a;
	logic [width-1:0]      operand_b;
	logic                  wb_commit;
	logic [REG_ADDR_W-1:0] wb_rd;
	logic [width-1:0]      wb_data;

	// Architectural state and expected commits in program order
	integer                seed;
	logic [width-1:0]      model_regs [32];
	logic [REG_ADDR_W-1:0] exp_rd_q [$];
	logic [width-1:0]      exp_data_q [$];
	int                    cycle;
	int                    issued;
	int                    first_commit_cycle;
	logic                  pending;
	logic                  first_seen;
	logic                  first_checked;

	operand_stage #(.width(width)) operand_stage_inst (
		.clk        (clk),
		.reset      (reset),
		.insn       (insn),
		.insn_valid (insn_valid),
		.id_freeze  (id_freeze),
		.ex_freeze  (ex_freeze),
		.operand_a  (operand_a),
		.operand_b  (operand_b),
		.wb_commit  (wb_commit),
		.wb_rd      (wb_rd),
		.wb_data    (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Watchdog sized from the instruction count
	initial begin
		#(clk_period * (n_insn * max_cpi + reset_cycles + 20));
		$display("Watchdog: pipeline did not drain in time");
		stop_with_failure();
	end

	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "run stopped");
	endtask

	task automatic value_error(input string test, input logic [31:0] exp, input logic [31:0] act);
		$display("Error: %s expected %h actual %h", test, exp, act);
		stop_with_failure();
	endtask

	// Random instruction, mostly known opcodes, one unknown
	task automatic make_insn();
		logic [31:0] r;
		r = $random(seed);
		insn = '0;
		case (r[2:0])
			3'd0:    insn.r_fmt.opcode = OP_ADD;
			3'd1:    insn.r_fmt.opcode = OP_SUB;
			3'd2:    insn.r_fmt.opcode = OP_AND;
			3'd3:    insn.r_fmt.opcode = OP_OR;
			3'd4:    insn.r_fmt.opcode = OP_XOR;
			3'd7:    insn.r_fmt.opcode = 6'h3f;
			default: insn.r_fmt.opcode = OP_ADDI;
		endcase
		insn.r_fmt.rd = {3'b000, r[4:3]};
		insn.r_fmt.ra = {3'b000, r[6:5]};
		insn.r_fmt.rb = {3'b000, r[8:7]};
		if (insn.i_fmt.opcode == OP_ADDI) begin
			insn.i_fmt.imm = r[31:16];
		end
		insn_valid = (r[14:11] != 4'd0);
	endtask

	// Result computed in program order from the operand rules
	task automatic accept_insn();
		logic [width-1:0] a;
		logic [width-1:0] b;
		logic [width-1:0] res;
		logic             known;
		a = model_regs[insn.r_fmt.ra];
		if (insn.i_fmt.opcode == OP_ADDI) begin
			// Sign-extended immediate takes the place of rb
			b = {{(width-16){insn.i_fmt.imm[15]}}, insn.i_fmt.imm};
		end else begin
			b = model_regs[insn.r_fmt.rb];
		end
		res   = '0;
		known = 1'b1;
		case (insn.r_fmt.opcode)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_ADDI: res = a + b;
			default: known = 1'b0;
		endcase
		if (insn_valid && known) begin
			// Entered EX on the last edge so its operands sit in the registers
			assert (operand_a == a) else value_error("operand_a", a, operand_a);
			assert (operand_b == b) else value_error("operand_b", b, operand_b);
			if (!first_seen) begin
				// Presented last cycle, so WB two cycles after that
				first_commit_cycle = cycle + 1;
				first_seen = 1'b1;
			end
			exp_rd_q.push_back(insn.r_fmt.rd);
			exp_data_q.push_back(res);
			if (insn.r_fmt.rd != '0) begin
				model_regs[insn.r_fmt.rd] = res;
			end
		end
	endtask

	task automatic check_commit();
		logic [REG_ADDR_W-1:0] e_rd;
		logic [width-1:0]      e_data;
		if (wb_commit) begin
			assert (exp_rd_q.size() > 0) else begin
				$display("Error: commit seen with no instruction outstanding");
				stop_with_failure();
			end
			if (!first_checked) begin
				assert (cycle == first_commit_cycle)
					else value_error("first_commit_cycle", first_commit_cycle, cycle);
				first_checked = 1'b1;
			end
			e_rd   = exp_rd_q.pop_front();
			e_data = exp_data_q.pop_front();
			assert (wb_rd == e_rd) else value_error("commit_rd", e_rd, wb_rd);
			assert (wb_data == e_data) else value_error("commit_data", e_data, wb_data);
		end
	endtask

	initial begin
		logic [31:0] r;
		seed          = seed_init;
		insn          = '0;
		insn_valid    = 1'b0;
		id_freeze     = 1'b0;
		ex_freeze     = 1'b0;
		reset         = 1'b1;
		cycle         = 0;
		issued        = 0;
		pending       = 1'b0;
		first_seen    = 1'b0;
		first_checked = 1'b0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (reset_cycles) begin
			@(negedge clk);
			assert (!wb_commit) else value_error("reset_commit", 0, wb_commit);
		end
		reset = 1'b0;

		// Main stimulus loop
		while (issued < n_insn) begin
			@(negedge clk);
			cycle++;
			check_commit();
			if (pending && !id_freeze && !ex_freeze) begin
				accept_insn();
				issued++;
				pending = 1'b0;
			end
			if (!pending) begin
				make_insn();
				pending = 1'b1;
			end
			r = $random(seed);
			// No freezes before the first commit so its latency is exact
			id_freeze = first_checked && (r[2:0] < 3'd2);
			ex_freeze = first_checked && (r[5:3] == 3'd0);
		end

		// Drain with no freezes
		insn_valid = 1'b0;
		id_freeze  = 1'b0;
		ex_freeze  = 1'b0;
		repeat (6) begin
			@(negedge clk);
			cycle++;
			check_commit();
		end
		if (exp_rd_q.size() == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Error: %0d instructions never committed", exp_rd_q.size());
			stop_with_failure();
		end
	end

endmodule

// ==== filelist.f ====
opstage_pkg.sv
reg_file.sv
forward_select.sv
operand_muxes.sv
exec_unit.sv
operand_stage.sv
operand_muxes_asserts.sv
tb_operand_stage.sv

// ==== Makefile ====
# Verilator build and run for the operand stage testbench

VERILATOR ?= verilator
TOP       ?= tb_operand_stage
SEED      ?= 28448
LOG       ?= sim.log
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
FAIL_MSG  := Done: errors found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: VERILATOR TOP SEED LOG FILELIST BUILD"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Gseed_init=$(SEED) --Mdir $(BUILD) -f $(FILELIST)
	@status=0; ./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || status=1; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
